// File: logic/spi_mem_pkg.sv
// shared widths, constants and packed structs for the SPI slave memory
// every design file refers to these by scoped name

package spi_mem_pkg;

	// memory geometry
	localparam int addr_w    = 7;
	localparam int data_w    = 8;
	localparam int mem_depth = 128;

	// two flops ahead of the edge detector
	localparam int sync_stages = 2;

	// bit counter counts 0 to 8 inside one byte
	localparam int cnt_w = 4;
	localparam logic [cnt_w-1:0] bits_per_byte = cnt_w'(data_w);

	// raw pins as they arrive at the top
	typedef struct packed {
		logic spi_clk;
		logic cs_n;
		logic mosi;
	} spi_pins_t;

	// idle bus with cs_n high and spi_clk low
	localparam spi_pins_t pins_idle = '{spi_clk: 1'b0, cs_n: 1'b1, mosi: 1'b0};

	// synchronized view of the bus with one-sclk strobes
	typedef struct packed {
		logic rise;
		logic fall;
		logic cs_n;
		logic mosi;
	} spi_evt_t;

	// memory access from the transfer FSM
	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
		logic              we;
	} mem_req_t;

endpackage

// File: logic/spi_input_sync.sv
// brings spi_clk, cs_n and mosi into the sclk domain
// and turns spi_clk transitions into one-cycle rise and fall strobes
`timescale 1ns/1ns

module spi_input_sync (
	input  logic                  sclk,
	input  logic                  rst_n,
	input  spi_mem_pkg::spi_pins_t pins,
	output spi_mem_pkg::spi_evt_t  evt
);

	// synchronizer chain with index 0 facing the pins
	spi_mem_pkg::spi_pins_t sync_q [spi_mem_pkg::sync_stages];

	// previous synchronized spi_clk sample
	logic hist_clk;

	always_ff @(posedge sclk) begin
		if (!rst_n) begin
			// start from an idle bus so no edge is seen out of reset
			for (int i = 0; i < spi_mem_pkg::sync_stages; i++) begin
				sync_q[i] <= spi_mem_pkg::pins_idle;
			end
		end else begin
			sync_q[0] <= pins;
			for (int i = 1; i < spi_mem_pkg::sync_stages; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	always_ff @(posedge sclk) begin
		if (!rst_n) begin
			hist_clk <= spi_mem_pkg::pins_idle.spi_clk;
		end else begin
			hist_clk <= sync_q[spi_mem_pkg::sync_stages-1].spi_clk;
		end
	end

	// strobes compare the last stage with the history flop
	// cs_n and mosi come from the same stage to stay aligned
	always_comb begin
		evt.rise = sync_q[spi_mem_pkg::sync_stages-1].spi_clk & ~hist_clk;
		evt.fall = ~sync_q[spi_mem_pkg::sync_stages-1].spi_clk & hist_clk;
		evt.cs_n = sync_q[spi_mem_pkg::sync_stages-1].cs_n;
		evt.mosi = sync_q[spi_mem_pkg::sync_stages-1].mosi;
	end

endmodule

// File: logic/spi_shift_reg.sv
// byte shifter between the SPI pins and the memory
// shifts mosi in on rise strobes, presents the top bit on miso at fall strobes
`timescale 1ns/1ns

module spi_shift_reg (
	input  logic                               sclk,
	input  logic                               rst_n,
	input  spi_mem_pkg::spi_evt_t              evt,
	input  logic                               load,
	input  logic [spi_mem_pkg::data_w-1:0]     load_data,
	output logic [spi_mem_pkg::data_w-1:0]     pdata,
	output logic                               miso
);

	logic [spi_mem_pkg::data_w-1:0] sreg;
	logic                           miso_q;

	// load from memory beats a shift in the same cycle
	always_ff @(posedge sclk) begin
		if (load) begin
			sreg <= load_data;
		end else if (evt.rise) begin
			// msb first so the new bit enters at the bottom
			sreg <= {sreg[spi_mem_pkg::data_w-2:0], evt.mosi};
		end
	end

	// miso changes on the falling spi_clk so the master samples
	// a stable bit on the next rise
	always_ff @(posedge sclk) begin
		if (!rst_n) begin
			miso_q <= 1'b0;
		end else if (evt.fall) begin
			miso_q <= sreg[spi_mem_pkg::data_w-1];
		end
	end

	assign pdata = sreg;
	assign miso  = miso_q;

endmodule

// File: logic/spi_xfer_fsm.sv
// transaction control for one 16-bit SPI frame of an address byte and a data byte
// issues the memory write, the read-data load and the miso output enable
`timescale 1ns/1ns

module spi_xfer_fsm (
	input  logic                           sclk,
	input  logic                           rst_n,
	input  spi_mem_pkg::spi_evt_t          evt,
	input  logic [spi_mem_pkg::data_w-1:0] pdata,
	output spi_mem_pkg::mem_req_t          req,
	output logic                           load,
	output logic                           miso_oe
);

	// one-hot states
	typedef enum logic [4:0] {
		st_idle  = 5'b00001,
		st_addr  = 5'b00010,
		st_write = 5'b00100,
		st_read  = 5'b01000,
		st_done  = 5'b10000
	} state_t;

	state_t                          state;
	logic [spi_mem_pkg::cnt_w-1:0]   cnt;
	logic [spi_mem_pkg::addr_w-1:0]  addr_q;
	// set on a read and doubles as the output enable
	logic                            rw_q;

	logic byte_full;
	logic addr_latch;
	logic wr_strobe;

	// high in the cycle after the rise that completed a byte
	assign byte_full  = (cnt == spi_mem_pkg::bits_per_byte);
	assign addr_latch = (state == st_addr) && byte_full && !evt.cs_n;
	assign wr_strobe  = (state == st_write) && byte_full && !evt.cs_n;

	always_ff @(posedge sclk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else if (evt.cs_n) begin
			// deselect aborts whatever is in flight
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					state <= st_addr;
				end
				st_addr: begin
					if (byte_full) begin
						state <= pdata[0] ? st_read : st_write;
					end
				end
				st_write, st_read: begin
					if (byte_full) begin
						state <= st_done;
					end
				end
				st_done: begin
					// extra bits are ignored until cs_n rises
					state <= st_done;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// bit counter restarts for each byte and parks at 8 in done
	always_ff @(posedge sclk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (evt.cs_n) begin
			cnt <= '0;
		end else if (byte_full && state != st_done) begin
			cnt <= '0;
		end else if (evt.rise && !byte_full) begin
			cnt <= cnt + 1'b1;
		end
	end

	// upper seven bits of the first byte
	always_ff @(posedge sclk) begin
		if (addr_latch) begin
			addr_q <= pdata[spi_mem_pkg::data_w-1 -: spi_mem_pkg::addr_w];
		end
	end

	always_ff @(posedge sclk) begin
		if (!rst_n) begin
			rw_q <= 1'b0;
		end else if (evt.cs_n) begin
			rw_q <= 1'b0;
		end else if (addr_latch) begin
			rw_q <= pdata[0];
		end
	end

	// address bypasses the register while it is being latched,
	// so the read load sees the right byte in the same cycle
	always_comb begin
		if (addr_latch) begin
			req.addr = pdata[spi_mem_pkg::data_w-1 -: spi_mem_pkg::addr_w];
		end else begin
			req.addr = addr_q;
		end
		req.wdata = pdata;
		req.we    = wr_strobe;
	end

	assign load    = addr_latch && pdata[0];
	assign miso_oe = rw_q;

endmodule

// File: logic/spi_data_mem.sv
// 128-byte register file behind the SPI slave
// synchronous write on we, combinational read at the request address
`timescale 1ns/1ns

module spi_data_mem (
	input  logic                           sclk,
	input  logic                           rst_n,
	input  spi_mem_pkg::mem_req_t          req,
	output logic [spi_mem_pkg::data_w-1:0] rdata
);

	logic [spi_mem_pkg::data_w-1:0] mem [spi_mem_pkg::mem_depth];

	// whole array reads back as zero after reset
	always_ff @(posedge sclk) begin
		if (!rst_n) begin
			for (int i = 0; i < spi_mem_pkg::mem_depth; i++) begin
				mem[i] <= '0;
			end
		end else if (req.we) begin
			mem[req.addr] <= req.wdata;
		end
	end

	// async read
	assign rdata = mem[req.addr];

endmodule

// File: logic/spi_mem_top.sv
// SPI slave memory, mode 0, one address byte and one data byte per frame
// all logic runs on sclk and the SPI pins are sampled asynchronously
`timescale 1ns/1ns

module spi_mem_top (
	input  logic sclk,
	input  logic rst_n,
	input  logic spi_clk,
	input  logic cs_n,
	input  logic mosi,
	output logic miso,
	output logic miso_oe
);

	spi_mem_pkg::spi_pins_t         pins;
	spi_mem_pkg::spi_evt_t          evt;
	spi_mem_pkg::mem_req_t          req;
	logic [spi_mem_pkg::data_w-1:0] pdata;
	logic [spi_mem_pkg::data_w-1:0] rdata;
	logic                           load;
	logic                           miso_bit;

	assign pins = '{spi_clk: spi_clk, cs_n: cs_n, mosi: mosi};

	spi_input_sync sync_i (
		.sclk  (sclk),
		.rst_n (rst_n),
		.pins  (pins),
		.evt   (evt)
	);

	spi_shift_reg shift_i (
		.sclk      (sclk),
		.rst_n     (rst_n),
		.evt       (evt),
		.load      (load),
		.load_data (rdata),
		.pdata     (pdata),
		.miso      (miso_bit)
	);

	spi_xfer_fsm fsm_i (
		.sclk    (sclk),
		.rst_n   (rst_n),
		.evt     (evt),
		.pdata   (pdata),
		.req     (req),
		.load    (load),
		.miso_oe (miso_oe)
	);

	spi_data_mem mem_i (
		.sclk  (sclk),
		.rst_n (rst_n),
		.req   (req),
		.rdata (rdata)
	);

	// shifter bits leak out during writes so miso stays at 0 unless enabled
	assign miso = miso_bit & miso_oe;

endmodule

// File: dv/spi_mem_tb.sv
// testbench for the SPI slave memory that drives random mode 0 frames as an SPI master
// and checks read data and the miso enable against a byte model of the memory
`timescale 1ns/1ns

module spi_mem_tb;

	// master timing in sclk cycles
	localparam int half_cycles = 8;
	localparam int bit_cycles  = 2 * half_cycles;
	localparam int idle_cycles = 8;
	localparam int frame_bits  = 16;

	// test lengths
	localparam int n_reset_reads  = 8;
	localparam int n_wr_rd        = 4;
	localparam int n_random       = 300;
	localparam int n_abort        = 10;
	localparam int n_extra        = 10;
	localparam int max_extra_bits = 8;

	// every frame is its bits plus the idle time ahead of it
	localparam int n_txn = n_reset_reads + 2 * n_wr_rd + n_random + 2 * n_abort + 3 * n_extra;
	localparam int timeout_cycles = n_txn * (frame_bits * bit_cycles + idle_cycles)
		+ 2 * n_extra * max_extra_bits * bit_cycles + 2000;

	logic sclk;
	logic rst_n;
	logic spi_clk;
	logic cs_n;
	logic mosi;
	logic miso;
	logic miso_oe;

	// expected memory contents
	logic [7:0] model [128];

	int frame_errors   = 0;
	int monitor_errors = 0;
	int cycle_cnt      = 0;
	int cs_high_cycles = 0;

	// master is inside a write frame
	logic in_write = 1'b0;

	spi_mem_top dut_i (
		.sclk    (sclk),
		.rst_n   (rst_n),
		.spi_clk (spi_clk),
		.cs_n    (cs_n),
		.mosi    (mosi),
		.miso    (miso),
		.miso_oe (miso_oe)
	);

	initial begin
		sclk = 1'b0;
		forever #5 sclk = ~sclk;
	end

	always @(posedge sclk) begin
		cycle_cnt++;
		if (cycle_cnt >= timeout_cycles) begin
			$display("run timed out after %0d sclk cycles", cycle_cnt);
			$display("errors: %0d frame, %0d monitor, %0d total",
				frame_errors, monitor_errors, frame_errors + monitor_errors);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// enable and miso rules sampled mid-cycle
	always @(negedge sclk) begin
		if (cs_n) begin
			cs_high_cycles++;
		end else begin
			cs_high_cycles = 0;
		end
		if (rst_n) begin
			// synchronizer needs about 3 cycles to see cs_n high
			if (cs_high_cycles > 4 && miso_oe !== 1'b0) begin
				$display("mismatch at %0t: miso_oe expected 0 observed %b with cs_n high",
					$time, miso_oe);
				monitor_errors++;
			end
			if (in_write && !cs_n && miso_oe !== 1'b0) begin
				$display("mismatch at %0t: miso_oe expected 0 observed %b in a write",
					$time, miso_oe);
				monitor_errors++;
			end
			if (miso_oe === 1'b0 && miso !== 1'b0) begin
				$display("mismatch at %0t: miso expected 0 observed %b with miso_oe low",
					$time, miso);
				monitor_errors++;
			end
		end
	end

	// step n rising edges and then 1 ns on
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sclk);
		#1;
	endtask

	// one SPI frame of nbits with the address byte, the data byte and any extra bits
	task automatic run_frame(input logic rd, input logic [6:0] addr, input logic [7:0] wdata,
		input int nbits, output logic [7:0] rdata);
		logic [15:0] word;
		logic [7:0]  got;
		word = {addr, rd, wdata};
		got  = '0;
		wait_cycles(idle_cycles);
		cs_n     = 1'b0;
		in_write = !rd;
		for (int i = 0; i < nbits; i++) begin
			if (i < frame_bits) begin
				mosi = word[15-i];
			end else begin
				mosi = 1'($urandom_range(0, 1));
			end
			wait_cycles(half_cycles);
			spi_clk = 1'b1;
			if (rd && i >= 8 && i < frame_bits) begin
				got = {got[6:0], miso};
				if (miso_oe !== 1'b1) begin
					$display("mismatch at %0t: miso_oe expected 1 observed %b on read bit %0d",
						$time, miso_oe, i);
					frame_errors++;
				end
			end
			wait_cycles(half_cycles);
			spi_clk = 1'b0;
		end
		cs_n     = 1'b1;
		in_write = 1'b0;
		mosi     = 1'b0;
		rdata    = got;
	endtask

	// model follows only writes that sent all 16 bits
	task automatic write_byte(input logic [6:0] addr, input logic [7:0] data, input int nbits);
		logic [7:0] unused;
		run_frame(1'b0, addr, data, nbits, unused);
		if (nbits >= frame_bits) begin
			model[addr] = data;
		end
	endtask

	task automatic read_and_compare(input logic [6:0] addr, input int nbits);
		logic [7:0] got;
		run_frame(1'b1, addr, 8'($urandom), nbits, got);
		if (got !== model[addr]) begin
			$display("mismatch at %0t: miso read of addr 0x%02h expected 0x%02h observed 0x%02h",
				$time, addr, model[addr], got);
			frame_errors++;
		end
	endtask

	initial begin
		logic [6:0] a;
		logic [7:0] d;
		logic       rd;
		int         k;

		rst_n   = 1'b0;
		spi_clk = 1'b0;
		cs_n    = 1'b1;
		mosi    = 1'b0;
		void'($urandom(25609));
		for (int i = 0; i < 128; i++) begin
			model[i] = '0;
		end
		wait_cycles(4);
		rst_n = 1'b1;

		// memory reads back as zero out of reset
		for (int i = 0; i < n_reset_reads; i++) begin
			read_and_compare(7'($urandom_range(0, 127)), frame_bits);
		end

		// single write then read-back
		for (int i = 0; i < n_wr_rd; i++) begin
			a = 7'($urandom_range(0, 127));
			d = 8'($urandom);
			write_byte(a, d, frame_bits);
			read_and_compare(a, frame_bits);
		end

		// random mix
		for (int i = 0; i < n_random; i++) begin
			rd = 1'($urandom_range(0, 1));
			a  = 7'($urandom_range(0, 127));
			if (rd) begin
				read_and_compare(a, frame_bits);
			end else begin
				write_byte(a, 8'($urandom), frame_bits);
			end
		end

		// write cut short by cs_n with data that differs from the stored byte
		for (int i = 0; i < n_abort; i++) begin
			a = 7'($urandom_range(0, 127));
			d = model[a] ^ 8'($urandom_range(1, 255));
			k = int'($urandom_range(1, frame_bits - 1));
			write_byte(a, d, k);
			read_and_compare(a, frame_bits);
		end

		// extra bits after the frame are ignored
		for (int i = 0; i < n_extra; i++) begin
			a = 7'($urandom_range(0, 127));
			k = frame_bits + int'($urandom_range(1, max_extra_bits));
			write_byte(a, 8'($urandom), k);
			k = frame_bits + int'($urandom_range(1, max_extra_bits));
			read_and_compare(a, k);
			read_and_compare(a, frame_bits);
		end

		wait_cycles(idle_cycles);
		$display("errors: %0d frame, %0d monitor, %0d total",
			frame_errors, monitor_errors, frame_errors + monitor_errors);
		if (frame_errors + monitor_errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: flist.f
logic/spi_mem_pkg.sv
logic/spi_input_sync.sv
logic/spi_shift_reg.sv
logic/spi_xfer_fsm.sv
logic/spi_data_mem.sv
logic/spi_mem_top.sv
dv/spi_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= spi_mem_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
